// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and codes

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 3;

  localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

  // major opcodes, rv32i base set
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 values the decoder cares about
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // controller and lsu state codes
  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_FETCH = 3'd1;
  localparam logic [2:0] S_WAIT  = 3'd2;
  localparam logic [2:0] S_EXEC  = 3'd3;
  localparam logic [2:0] S_MEM   = 3'd4;
  localparam logic [1:0] L_IDLE  = 2'd0;
  localparam logic [1:0] L_REQ   = 2'd1;
  localparam logic [1:0] L_WAIT  = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // instruction word, one view per encoding format

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } rv_instr_u;

endpackage

`default_nettype wire

// ==== src/rv_alu.sv ====
`default_nettype none

module rv_alu (
  input  logic [rv_pkg::ALU_OP_W-1:0] operator_i,
  input  logic [rv_pkg::XLEN-1:0]     operand_a_i,
  input  logic [rv_pkg::XLEN-1:0]     operand_b_i,
  output logic [rv_pkg::XLEN-1:0]     result_o,
  output logic                        equal_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            less;

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;
  assign less = $signed(operand_a_i) < $signed(operand_b_i);  // signed compare for slt

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less};
      default: result_o = sum;  // unused codes fall back to add
    endcase
  end

  // branch compare
  assign equal_o = (operand_a_i == operand_b_i);

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`default_nettype none

module rv_regfile (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i
);
  import rv_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs_q [1:(2**REG_ADDR_W)-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int k = 1; k < 2**REG_ADDR_W; k++) begin
        regs_q[k] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;  // writes to x0 dropped
    end
  end

  // asynchronous read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== src/rv_fetch.sv ====
`default_nettype none

module rv_fetch (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [rv_pkg::XLEN-1:0] boot_addr_i,
  input  logic                    fetch_start_i,
  input  logic                    retire_i,
  input  logic                    branch_taken_i,
  input  logic [rv_pkg::XLEN-1:0] branch_offset_i,
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  output logic [rv_pkg::XLEN-1:0] instr_addr_o,
  input  logic [rv_pkg::XLEN-1:0] instr_rdata_i,
  output logic                    instr_valid_o,
  output rv_pkg::rv_instr_u       instr_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            req_q;   // request out, no grant yet
  logic            wait_q;  // granted, rvalid pending
  rv_instr_u       instr_q;

  // request goes out in the start cycle itself
  assign instr_req_o   = fetch_start_i | req_q;
  assign instr_addr_o  = pc_q;  // pc only moves at retire
  assign instr_valid_o = wait_q & instr_rvalid_i;
  assign instr_o       = instr_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q   <= boot_addr_i;
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (instr_req_o && instr_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end else if (fetch_start_i) begin
        req_q  <= 1'b1;  // hold until granted
      end
      if (instr_valid_o) wait_q <= 1'b0;
      if (retire_i) pc_q <= pc_q + (branch_taken_i ? branch_offset_i : XLEN'(4));
    end
  end

  // instruction word held until the next fetch answers
  always_ff @(posedge clk_i) begin
    if (instr_valid_o) instr_q <= instr_rdata_i;
  end

endmodule

`default_nettype wire

// ==== src/rv_lsu.sv ====
`default_nettype none

module rv_lsu (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    lsu_req_i,
  input  logic                    lsu_we_i,
  input  logic [rv_pkg::XLEN-1:0] lsu_addr_i,
  input  logic [rv_pkg::XLEN-1:0] lsu_wdata_i,
  output logic                    lsu_done_o,
  output logic [rv_pkg::XLEN-1:0] lsu_rdata_o,
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  output logic                    data_we_o,
  output logic [rv_pkg::XLEN-1:0] data_addr_o,
  output logic [rv_pkg::XLEN-1:0] data_wdata_o,
  input  logic [rv_pkg::XLEN-1:0] data_rdata_i
);
  import rv_pkg::*;

  logic [1:0]      state_q;
  logic            we_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= L_IDLE;
    end else begin
      case (state_q)
        L_IDLE: if (lsu_req_i) state_q <= L_REQ;
        L_REQ:  if (data_gnt_i) state_q <= we_q ? L_IDLE : L_WAIT;  // store ends here
        L_WAIT: if (data_rvalid_i) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // access captured once, stable through the grant wait
  always_ff @(posedge clk_i) begin
    if ((state_q == L_IDLE) && lsu_req_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign data_req_o   = (state_q == L_REQ);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu_done_o  = (data_req_o && data_gnt_i && we_q)
                     || ((state_q == L_WAIT) && data_rvalid_i);
  assign lsu_rdata_o = data_rdata_i;  // valid with done on loads

endmodule

`default_nettype wire

// ==== src/rv_controller.sv ====
`default_nettype none

module rv_controller (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_enable_i,
  output logic                          core_busy_o,
  output logic                          fetch_start_o,
  input  logic                          instr_valid_i,
  input  rv_pkg::rv_instr_u             instr_i,
  output logic                          retire_o,
  output logic                          branch_taken_o,
  output logic [rv_pkg::XLEN-1:0]       branch_offset_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [rv_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [rv_pkg::XLEN-1:0]       rf_rdata_b_i,
  output logic                          rf_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_pkg::XLEN-1:0]       rf_wdata_o,
  output logic [rv_pkg::ALU_OP_W-1:0]   alu_operator_o,
  output logic [rv_pkg::XLEN-1:0]       alu_operand_a_o,
  output logic [rv_pkg::XLEN-1:0]       alu_operand_b_o,
  input  logic [rv_pkg::XLEN-1:0]       alu_result_i,
  input  logic                          alu_equal_i,
  output logic                          lsu_req_o,
  output logic                          lsu_we_o,
  output logic [rv_pkg::XLEN-1:0]       lsu_addr_o,
  output logic [rv_pkg::XLEN-1:0]       lsu_wdata_o,
  input  logic                          lsu_done_i,
  input  logic [rv_pkg::XLEN-1:0]       lsu_rdata_i
);
  import rv_pkg::*;

  logic [2:0]          state_q;
  logic [2:0]          state_d;
  logic [2:0]          after_retire;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_s;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     imm;
  logic [ALU_OP_W-1:0] alu_op;
  logic                zero_a, use_imm, wb_alu;
  logic                is_load, is_store, is_branch, is_mem;
  logic                in_exec, in_mem;

  //////////////////////////////////////////////////////////////////////
  // decode

  assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_u = {instr_i.u.imm, 12'b0};
  assign branch_offset_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                            instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};

  always_comb begin
    alu_op    = ALU_ADD;
    zero_a    = 1'b0;
    use_imm   = 1'b0;
    imm       = imm_i;
    wb_alu    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    case (instr_i.r.opcode)
      OPC_OP: begin
        wb_alu = 1'b1;
        case (instr_i.r.funct3)
          F3_ADD_SUB: alu_op = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    wb_alu = 1'b0;  // shifts, sltu retire as no-op
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        wb_alu  = (instr_i.i.funct3 == F3_ADD_SUB);  // addi only
      end
      OPC_LUI: begin
        zero_a  = 1'b1;  // 0 + upper imm
        use_imm = 1'b1;
        imm     = imm_u;
        wb_alu  = 1'b1;
      end
      OPC_LOAD: begin
        use_imm = 1'b1;
        is_load = 1'b1;
      end
      OPC_STORE: begin
        use_imm  = 1'b1;
        imm      = imm_s;
        is_store = 1'b1;
      end
      OPC_BRANCH: is_branch = (instr_i.b.funct3 == F3_BEQ) || (instr_i.b.funct3 == F3_BNE);
      default: ;
    endcase
  end

  assign is_mem = is_load | is_store;

  //////////////////////////////////////////////////////////////////////
  // sequencing

  assign after_retire = fetch_enable_i ? S_FETCH : S_IDLE;  // drain then stop

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (fetch_enable_i) state_d = S_FETCH;
      S_FETCH: state_d = S_WAIT;
      S_WAIT:  if (instr_valid_i) state_d = S_EXEC;
      S_EXEC:  state_d = is_mem ? S_MEM : after_retire;
      S_MEM:   if (lsu_done_i) state_d = after_retire;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= S_IDLE;
    else          state_q <= state_d;
  end

  assign in_exec       = (state_q == S_EXEC);
  assign in_mem        = (state_q == S_MEM);
  assign core_busy_o   = (state_q != S_IDLE);
  assign fetch_start_o = (state_q == S_FETCH);

  // beq taken on equal, bne (funct3[0]) on not equal
  assign branch_taken_o = in_exec & is_branch & (alu_equal_i ^ instr_i.b.funct3[0]);
  assign retire_o       = (in_exec & ~is_mem) | (in_mem & lsu_done_i);

  //////////////////////////////////////////////////////////////////////
  // datapath steering

  assign rf_raddr_a_o    = instr_i.r.rs1;
  assign rf_raddr_b_o    = instr_i.r.rs2;
  assign alu_operator_o  = alu_op;
  assign alu_operand_a_o = zero_a ? '0 : rf_rdata_a_i;
  assign alu_operand_b_o = use_imm ? imm : rf_rdata_b_i;

  assign rf_we_o    = (in_exec & wb_alu) | (in_mem & is_load & lsu_done_i);
  assign rf_waddr_o = instr_i.r.rd;
  assign rf_wdata_o = in_mem ? lsu_rdata_i : alu_result_i;  // load data or alu

  assign lsu_req_o   = in_exec & is_mem;
  assign lsu_we_o    = is_store;
  assign lsu_addr_o  = alu_result_i;  // rs1 + offset
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`default_nettype none

module rv_core (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [rv_pkg::XLEN-1:0] boot_addr_i,
  input  logic                    fetch_enable_i,
  output logic                    core_busy_o,
  // instruction memory
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  output logic [rv_pkg::XLEN-1:0] instr_addr_o,
  input  logic [rv_pkg::XLEN-1:0] instr_rdata_i,
  // data memory
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  output logic                    data_we_o,
  output logic [rv_pkg::XLEN-1:0] data_addr_o,
  output logic [rv_pkg::XLEN-1:0] data_wdata_o,
  input  logic [rv_pkg::XLEN-1:0] data_rdata_i
);
  import rv_pkg::*;

  logic                  fetch_start, instr_valid, retire, branch_taken;
  logic [XLEN-1:0]       branch_offset;
  rv_instr_u             instr;
  logic [REG_ADDR_W-1:0] rf_raddr_a, rf_raddr_b, rf_waddr;
  logic [XLEN-1:0]       rf_rdata_a, rf_rdata_b, rf_wdata;
  logic                  rf_we;
  logic [ALU_OP_W-1:0]   alu_operator;
  logic [XLEN-1:0]       alu_operand_a, alu_operand_b, alu_result;
  logic                  alu_equal;
  logic                  lsu_req, lsu_we, lsu_done;
  logic [XLEN-1:0]       lsu_addr, lsu_wdata, lsu_rdata;

  //////////////////////////////////////////////////////////////////////
  // control
  rv_controller u_controller (
    .clk_i, .rst_n_i, .fetch_enable_i, .core_busy_o,
    .fetch_start_o(fetch_start), .instr_valid_i(instr_valid), .instr_i(instr),
    .retire_o(retire), .branch_taken_o(branch_taken), .branch_offset_o(branch_offset),
    .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
    .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .alu_operator_o(alu_operator), .alu_operand_a_o(alu_operand_a),
    .alu_operand_b_o(alu_operand_b), .alu_result_i(alu_result), .alu_equal_i(alu_equal),
    .lsu_req_o(lsu_req), .lsu_we_o(lsu_we), .lsu_addr_o(lsu_addr),
    .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // fetch, pc lives here
  rv_fetch u_fetch (
    .clk_i, .rst_n_i, .boot_addr_i,
    .fetch_start_i(fetch_start), .retire_i(retire),
    .branch_taken_i(branch_taken), .branch_offset_i(branch_offset),
    .instr_req_o, .instr_gnt_i, .instr_rvalid_i, .instr_addr_o, .instr_rdata_i,
    .instr_valid_o(instr_valid), .instr_o(instr)
  );

  //////////////////////////////////////////////////////////////////////
  // register file and alu
  rv_regfile u_regfile (
    .clk_i, .rst_n_i,
    .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
    .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  rv_alu u_alu (
    .operator_i(alu_operator), .operand_a_i(alu_operand_a), .operand_b_i(alu_operand_b),
    .result_o(alu_result), .equal_o(alu_equal)
  );

  //////////////////////////////////////////////////////////////////////
  // load/store, word only
  rv_lsu u_lsu (
    .clk_i, .rst_n_i,
    .lsu_req_i(lsu_req), .lsu_we_i(lsu_we), .lsu_addr_i(lsu_addr),
    .lsu_wdata_i(lsu_wdata), .lsu_done_o(lsu_done), .lsu_rdata_o(lsu_rdata),
    .data_req_o, .data_gnt_i, .data_rvalid_i, .data_we_o,
    .data_addr_o, .data_wdata_o, .data_rdata_i
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // period 20
  end

  // 10 cycles of reset at start, again on each restart pulse
  always begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #2 rst_n_o = 1'b1;  // released just after the edge
    @(posedge restart_i);
  end

endmodule

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam logic [XLEN-1:0] BOOT = 32'h0000_0080;
  localparam int TIMEOUT = 5000;  // cycles per wait

  logic            clk, rst_n, restart;
  logic            fetch_enable, core_busy;
  logic [XLEN-1:0] boot_addr;
  logic            instr_req, instr_gnt, instr_rvalid;
  logic [XLEN-1:0] instr_addr, instr_rdata;
  logic            data_req, data_gnt, data_rvalid, data_we;
  logic [XLEN-1:0] data_addr, data_wdata, data_rdata;

  logic [XLEN-1:0] imem [0:255];  // word index = addr[9:2]
  logic [XLEN-1:0] dmem [0:255];
  logic [XLEN-1:0] regs [0:31];   // register file model
  logic [XLEN-1:0] st_addr_q[$], st_data_q[$];    // stores seen on the bus
  logic [XLEN-1:0] exp_addr_q[$], exp_data_q[$];  // stores the model expects
  logic [XLEN-1:0] end_pc;
  logic [7:0]      pc_idx;
  int              skip_n, gnt_max;
  integer          seed = 32'h4c47;
  string           test_name;

  tb_clock_gen clock_gen (.restart_i(restart), .clk_o(clk), .rst_n_o(rst_n));

  rv_core DUT (
    .clk_i(clk), .rst_n_i(rst_n), .boot_addr_i(boot_addr),
    .fetch_enable_i(fetch_enable), .core_busy_o(core_busy),
    .instr_req_o(instr_req), .instr_gnt_i(instr_gnt), .instr_rvalid_i(instr_rvalid),
    .instr_addr_o(instr_addr), .instr_rdata_i(instr_rdata),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_we_o(data_we), .data_addr_o(data_addr), .data_wdata_o(data_wdata),
    .data_rdata_i(data_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compares

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input logic [XLEN-1:0] exp, act);
    if (act !== exp)
      stop_run($sformatf("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  task automatic check_addr(input string what, input logic [XLEN-1:0] exp, act);
    if (act !== exp)
      stop_run($sformatf("Error in %s, %s: expected address %h, actual %h",
                         test_name, what, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, act);
    if (act !== exp)
      stop_run($sformatf("Error in %s, %s: expected %b, actual %b", test_name, what, exp, act));
  endtask

  function automatic int rand_upto(input int max);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % (max + 1);
  endfunction

  task automatic sample_point();
    @(posedge clk);
    #1;  // outputs settled, drive phase is at +2
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory models, req/gnt/rvalid with random waits

  initial begin : instr_port
    int              wait_n;
    logic [XLEN-1:0] addr;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    forever begin
      sample_point();
      if (instr_req) begin
        addr   = instr_addr;
        wait_n = rand_upto(gnt_max);
        repeat (wait_n) begin
          sample_point();
          check_flag("instr req held", 1'b1, instr_req);
          check_addr("instr addr held", addr, instr_addr);
        end
        #1 instr_gnt = 1'b1;
        @(posedge clk);  // grant edge
        #2 instr_gnt = 1'b0;
        wait_n = rand_upto(3);
        repeat (wait_n) begin
          @(posedge clk);
          #2;
        end
        instr_rvalid = 1'b1;
        instr_rdata  = imem[addr[9:2]];
        @(posedge clk);
        #2 instr_rvalid = 1'b0;
      end
    end
  end

  initial begin : data_port
    int              wait_n;
    logic            we;
    logic [XLEN-1:0] addr, wdata;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    forever begin
      sample_point();
      if (data_req) begin
        we     = data_we;
        addr   = data_addr;
        wdata  = data_wdata;
        wait_n = rand_upto(gnt_max);
        repeat (wait_n) begin
          sample_point();
          check_flag("data req held", 1'b1, data_req);
          check_flag("data we held", we, data_we);
          check_addr("data addr held", addr, data_addr);
          check_word("data wdata held", wdata, data_wdata);
        end
        #1 data_gnt = 1'b1;
        @(posedge clk);
        #2 data_gnt = 1'b0;
        if (we) begin  // store is done at the grant
          dmem[addr[9:2]] = wdata;
          st_addr_q.push_back(addr);
          st_data_q.push_back(wdata);
        end else begin
          wait_n = rand_upto(3);
          repeat (wait_n) begin
            @(posedge clk);
            #2;
          end
          data_rvalid = 1'b1;
          data_rdata  = dmem[addr[9:2]];
          @(posedge clk);
          #2 data_rvalid = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // program builder, each instruction also steps the model

  task automatic start_program(input string name);
    test_name = name;
    pc_idx    = BOOT[9:2];
    skip_n    = 0;
    for (int k = 0; k < 256; k++) begin
      imem[k[7:0]] = 32'h0bad_0000 | {22'b0, k[7:0], 2'b00};  // low bits 00, a no-op
      dmem[k[7:0]] = 32'h5a5a_0000 ^ {22'b0, k[7:0], 2'b00};
    end
    for (int k = 0; k < 32; k++) regs[k[4:0]] = '0;
    st_addr_q.delete();
    st_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  // false when a taken branch jumps over this slot
  function automatic bit emit(input logic [XLEN-1:0] word);
    imem[pc_idx] = word;
    pc_idx = pc_idx + 8'd1;
    if (skip_n > 0) begin
      skip_n--;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic rr_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd, rs1, rs2);
    logic [XLEN-1:0] a, b, r;
    a = regs[rs1];
    b = regs[rs2];
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b010:  r = {31'b0, $signed(a) < $signed(b)};
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    if (emit({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP}) && rd != 5'd0) regs[rd] = r;
  endtask

  task automatic addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    logic [XLEN-1:0] r;
    r = regs[rs1] + {{20{imm[11]}}, imm};
    if (emit({imm, rs1, 3'b000, rd, OPC_OP_IMM}) && rd != 5'd0) regs[rd] = r;
  endtask

  task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
    if (emit({imm, rd, OPC_LUI}) && rd != 5'd0) regs[rd] = {imm, 12'b0};
  endtask

  // loaded word comes from the preset memory
  task automatic lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
    logic [XLEN-1:0] a;
    a = regs[rs1] + {{20{imm[11]}}, imm};
    if (emit({imm, rs1, 3'b010, rd, OPC_LOAD}) && rd != 5'd0) regs[rd] = dmem[a[9:2]];
  endtask

  task automatic sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    logic [XLEN-1:0] a;
    a = regs[rs1] + {{20{imm[11]}}, imm};
    if (emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE})) begin
      exp_addr_q.push_back(a);
      exp_data_q.push_back(regs[rs2]);
    end
  endtask

  // forward branch over skip instructions, beq or bne
  task automatic branch(input logic bne, input logic [4:0] rs1, rs2, skip);
    logic [12:0] off;
    logic        taken;
    off   = {6'b0, skip + 5'd1, 2'b00};
    taken = (regs[rs1] == regs[rs2]) ^ bne;
    if (emit({off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], OPC_BRANCH})
        && taken) skip_n = int'(skip);
  endtask

  task automatic halt_loop();
    end_pc = {22'b0, pc_idx, 2'b00};
    void'(emit({25'b0, OPC_BRANCH}));  // beq x0, x0, 0
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control

  task automatic restart_core();
    int n;
    restart = 1'b1;
    n = 0;
    do begin
      sample_point();
      restart = 1'b0;
      n++;
      if (n > 40) stop_run("timeout: reset was never released after a restart");
    end while (rst_n !== 1'b1);
    #1;
  endtask

  task automatic run_to_halt();
    int n;
    fetch_enable = 1'b1;
    n = 0;
    do begin
      sample_point();
      n++;
      if (n > TIMEOUT) stop_run("timeout: the program never reached its halt loop");
    end while (!(instr_req && instr_addr == end_pc));
    #1 fetch_enable = 1'b0;
    n = 0;
    do begin
      sample_point();
      n++;
      if (n > TIMEOUT) stop_run("timeout: the core stayed busy after fetch enable dropped");
    end while (core_busy);
    #1;
  endtask

  task automatic compare_stores();
    check_word("store count", XLEN'(exp_addr_q.size()), XLEN'(st_addr_q.size()));
    for (int k = 0; k < exp_addr_q.size(); k++) begin
      check_addr($sformatf("store %0d address", k), exp_addr_q[k], st_addr_q[k]);
      check_word($sformatf("store %0d data", k), exp_data_q[k], st_data_q[k]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic reset_and_boot();
    int n;
    start_program("reset_boot");
    halt_loop();
    for (n = 0; n < 5; n++) begin  // still inside the first reset
      sample_point();
      check_flag("instr_req in reset", 1'b0, instr_req);
      check_flag("data_req in reset", 1'b0, data_req);
      check_flag("core_busy in reset", 1'b0, core_busy);
    end
    n = 0;
    while (rst_n !== 1'b1) begin
      sample_point();
      n++;
      if (n > 40) stop_run("timeout: the first reset was never released");
    end
    repeat (3) begin  // out of reset, fetch enable still low
      sample_point();
      check_flag("instr_req before enable", 1'b0, instr_req);
      check_flag("data_req before enable", 1'b0, data_req);
      check_flag("core_busy before enable", 1'b0, core_busy);
    end
    #1 fetch_enable = 1'b1;
    n = 0;
    do begin
      sample_point();
      n++;
      if (n > 40) stop_run("timeout: no fetch request after fetch enable");
    end while (!instr_req);
    check_addr("first fetch", BOOT, instr_addr);
    #1;
    run_to_halt();
    compare_stores();
  endtask

  task automatic load_alu_program();
    addi(1, 0, 12'h123);
    addi(2, 0, 12'hffb);        // -5
    lui(3, 20'habcde);
    addi(3, 3, 12'h765);
    addi(0, 1, 12'h055);        // x0 stays zero
    rr_op(3'b000, 1'b0, 4, 1, 2);   // add
    rr_op(3'b000, 1'b1, 5, 1, 2);   // sub
    rr_op(3'b111, 1'b0, 6, 3, 1);   // and
    rr_op(3'b110, 1'b0, 7, 3, 2);   // or
    rr_op(3'b100, 1'b0, 8, 3, 1);   // xor
    rr_op(3'b010, 1'b0, 9, 2, 1);   // slt true, signed
    rr_op(3'b010, 1'b0, 10, 1, 2);  // slt false
    addi(11, 0, 12'h100);
    for (int k = 0; k <= 10; k++) sw(k[4:0], 11, {k[9:0], 2'b00});
    halt_loop();
  endtask

  task automatic alu_program();
    start_program("alu");
    load_alu_program();
    restart_core();
    run_to_halt();
    compare_stores();
  endtask

  task automatic load_sum();
    start_program("load_sum");
    dmem[8'h60] = 32'h1111_2222;  // words at 0x180
    dmem[8'h61] = 32'h0f0f_0f0f;
    dmem[8'h62] = 32'h8000_0001;
    addi(1, 0, 12'h180);
    lw(2, 1, 12'h000);
    lw(3, 1, 12'h004);
    lw(4, 1, 12'h008);
    rr_op(3'b000, 1'b0, 5, 2, 3);
    rr_op(3'b000, 1'b0, 5, 5, 4);
    sw(5, 1, 12'h00c);
    halt_loop();
    restart_core();
    run_to_halt();
    compare_stores();
    check_word("sum in memory", 32'h1111_2222 + 32'h0f0f_0f0f + 32'h8000_0001, dmem[8'h63]);
  endtask

  task automatic branch_paths();
    start_program("branch");
    addi(1, 0, 12'h007);
    addi(2, 0, 12'h007);
    addi(3, 0, 12'h009);
    addi(10, 0, 12'h200);  // marker base
    branch(1'b0, 1, 2, 1);  // beq taken
    sw(1, 10, 12'h000);
    sw(1, 10, 12'h004);
    branch(1'b0, 1, 3, 1);  // beq not taken
    sw(3, 10, 12'h008);
    branch(1'b1, 1, 3, 2);  // bne taken over two
    sw(1, 10, 12'h00c);
    sw(1, 10, 12'h010);
    sw(2, 10, 12'h014);
    branch(1'b1, 1, 2, 1);  // bne not taken
    sw(3, 10, 12'h018);
    halt_loop();
    restart_core();
    run_to_halt();
    compare_stores();
  endtask

  task automatic slow_grants();
    start_program("backpressure");
    load_alu_program();
    gnt_max = 15;  // long grant waits on both ports
    restart_core();
    run_to_halt();
    compare_stores();
    gnt_max = 3;
  endtask

  initial begin : main
    restart      = 1'b0;
    fetch_enable = 1'b0;
    boot_addr    = BOOT;
    gnt_max      = 3;
    reset_and_boot();
    alu_program();
    load_sum();
    branch_paths();
    slow_grants();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/rv_pkg.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_lsu.sv
src/rv_controller.sv
src/rv_core.sv
tb/tb_clock_gen.sv
tb/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module rv_core_tb
./obj_dir/Vrv_core_tb
